// File: Bender.yml
package:
  name: cached_rom

sources:
  - cache_pkg.sv
  - cache_ro_multi.sv
  - backing_rom.sv
  - miss_handler.sv
  - cached_rom_top.sv
  - target: simulation
    files:
      - tb_cached_rom.sv

// File: backing_rom.sv
/*
 * Slow block ROM loaded from rom_image.hex, fixed read latency.
 * Data and valid appear ROM_LATENCY cycles after the read strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module backing_rom import cache_pkg::*; #(
    parameter int ROM_LATENCY = 3  // cycles from i_rd to o_valid
) (
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_rd,
    input  wire  [ADDR_W-1:0] i_addr,
    output logic              o_valid,
    output logic [BLOCK_W-1:0] o_data
);
    localparam int DEPTH = 1 << ADDR_W;

    if (ROM_LATENCY < 1) begin : g_bad_latency
        $error("backing_rom needs ROM_LATENCY >= 1");
    end

    logic [BLOCK_W-1:0]     mem [DEPTH];
    logic [ROM_LATENCY-1:0] pend_sr;  // one bit per cycle in flight
    logic [ADDR_W-1:0]      addr_q;

    initial begin
        $readmemh("rom_image.hex", mem);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pend_sr <= '0;
        end else begin
            pend_sr[0] <= i_rd;
            for (int i = 1; i < ROM_LATENCY; i++) begin
                pend_sr[i] <= pend_sr[i-1];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd) begin
            addr_q <= i_addr;  // held until the next read
        end
    end

    assign o_valid = pend_sr[ROM_LATENCY-1];
    assign o_data  = mem[addr_q];

    // one read at a time
    a_no_overlap: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_rd |-> (pend_sr == '0)
    ) else $error("rom read issued while another read is in flight");

endmodule : backing_rom

`default_nettype wire

// File: build.f
cache_pkg.sv
cache_ro_multi.sv
backing_rom.sv
miss_handler.sv
cached_rom_top.sv
tb_cached_rom.sv

// File: cache_pkg.sv
/*
 * Shared widths, cache command/response structs and the miss handler states.
 * Imported by every module of the cached ROM.
 */
`default_nettype none

package cache_pkg;

    // tied to the hex image, not meant to vary
    localparam int ADDR_W  = 6;   // block address, 64 blocks
    localparam int BLOCK_W = 32;  // bits per block

    // one command to the cache, valid for one cycle
    typedef struct packed {
        logic               en;
        logic               wrt;   // 1 = fill, 0 = lookup
        logic [ADDR_W-1:0]  addr;  // block index, no byte offset
        logic [BLOCK_W-1:0] data;  // fill data, ignored on lookup
    } cache_cmd_t;

    // registered reply, one cycle after the command
    typedef struct packed {
        logic [BLOCK_W-1:0] data;
        logic               success;  // hit on read, accepted on write
    } cache_rsp_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK,
        ST_FETCH,
        ST_FILL,
        ST_RESPOND
    } handler_state_t;

endpackage : cache_pkg

`default_nettype wire

// File: cache_ro_multi.sv
/*
 * Set-associative read-only cache, block addressed, NMRU replacement on fill.
 * A write echoes its data and is refused if the tag is already present.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ro_multi import cache_pkg::*; #(
    parameter int WAY       = 2,  // blocks per set, at least 2
    parameter int BIT_INDEX = 2   // set index width
) (
    input  wire        i_clk,
    input  wire        i_rst,
    input  cache_cmd_t i_cmd,
    output cache_rsp_t o_rsp
);
    localparam int TAG_W = ADDR_W - BIT_INDEX;
    localparam int SETS  = 1 << BIT_INDEX;
    localparam int WAY_W = $clog2(WAY);

    if (WAY < 2) begin : g_bad_way
        $error("cache_ro_multi needs WAY >= 2");
    end
    if (BIT_INDEX >= ADDR_W) begin : g_bad_index
        $error("cache_ro_multi needs BIT_INDEX < ADDR_W");
    end

    logic [BLOCK_W-1:0] data_mem [SETS][WAY];
    logic [TAG_W-1:0]   tag_mem  [SETS][WAY];
    logic [WAY-1:0]     valid    [SETS];
    logic [WAY_W-1:0]   mru      [SETS];  // most recently used way

    logic [BIT_INDEX-1:0] set_idx;
    logic [TAG_W-1:0]     tag_in;
    logic                 hit;
    logic [WAY_W-1:0]     hit_way;
    logic                 has_free;
    logic [WAY_W-1:0]     free_way;
    logic [WAY_W-1:0]     victim_way;
    logic [WAY_W-1:0]     fill_way;
    logic                 do_read;
    logic                 do_write;
    logic [BLOCK_W-1:0]   rsp_data;
    logic                 rsp_success;

    assign set_idx = i_cmd.addr[BIT_INDEX-1:0];
    assign tag_in  = i_cmd.addr[ADDR_W-1:BIT_INDEX];

    // tag match, lowest invalid way and highest non-MRU way of the set
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        has_free   = 1'b0;
        free_way   = '0;
        victim_way = '0;
        for (int w = 0; w < WAY; w++) begin
            if (valid[set_idx][w] && tag_mem[set_idx][w] == tag_in) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (WAY_W'(w) != mru[set_idx]) begin
                victim_way = WAY_W'(w);  // last one wins, highest index
            end
        end
        // walk down so the lowest invalid way is kept
        for (int w = WAY - 1; w >= 0; w--) begin
            if (!valid[set_idx][w]) begin
                has_free = 1'b1;
                free_way = WAY_W'(w);
            end
        end
    end

    assign fill_way = has_free ? free_way : victim_way;
    assign do_read  = i_cmd.en && !i_cmd.wrt && hit;
    assign do_write = i_cmd.en && i_cmd.wrt && !hit;  // refused if present

    // block and tag storage, plus the reply data
    always_ff @(posedge i_clk) begin
        if (do_write) begin
            data_mem[set_idx][fill_way] <= i_cmd.data;
            tag_mem[set_idx][fill_way]  <= tag_in;
            rsp_data                    <= i_cmd.data;  // echo on fill
        end else if (do_read) begin
            rsp_data <= data_mem[set_idx][hit_way];
        end
    end

    // valid bits, MRU pointers and the success flag
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rsp_success <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
                mru[s]   <= '0;
            end
        end else begin
            rsp_success <= do_read || do_write;
            if (do_write) begin
                valid[set_idx][fill_way] <= 1'b1;
                mru[set_idx]             <= fill_way;
            end else if (do_read) begin
                mru[set_idx] <= hit_way;  // a hit refreshes the MRU
            end
        end
    end

    assign o_rsp = '{data: rsp_data, success: rsp_success};

    // the handler must never present a live command with a floating address
    a_cmd_addr_known: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_cmd.en |-> !$isunknown(i_cmd.addr)
    ) else $error("cache command enabled with unknown address %b", i_cmd.addr);

endmodule : cache_ro_multi

`default_nettype wire

// File: cached_rom_top.sv
/*
 * Cached read-only store: miss handler, set-associative cache and block ROM.
 * Pulse i_req with an address, wait for o_resp_valid; hold off while o_busy.
 */
`timescale 1ns/1ps
`default_nettype none

module cached_rom_top import cache_pkg::*; #(
    parameter int WAY         = 2,
    parameter int BIT_INDEX   = 2,  // 4 sets
    parameter int ROM_LATENCY = 3
) (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_req,
    input  wire  [ADDR_W-1:0]  i_req_addr,
    output logic               o_busy,
    output logic               o_resp_valid,
    output logic [BLOCK_W-1:0] o_resp_data,
    output logic               o_resp_hit
);
    cache_cmd_t         cache_cmd;
    cache_rsp_t         cache_rsp;
    logic               rom_rd;
    logic [ADDR_W-1:0]  rom_addr;
    logic               rom_valid;
    logic [BLOCK_W-1:0] rom_data;

    miss_handler u_handler (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_req_addr   (i_req_addr),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_hit   (o_resp_hit),
        .o_cache_cmd  (cache_cmd),
        .i_cache_rsp  (cache_rsp),
        .o_rom_rd     (rom_rd),
        .o_rom_addr   (rom_addr),
        .i_rom_valid  (rom_valid),
        .i_rom_data   (rom_data)
    );

    cache_ro_multi #(
        .WAY       (WAY),
        .BIT_INDEX (BIT_INDEX)
    ) u_cache (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_cmd (cache_cmd),
        .o_rsp (cache_rsp)
    );

    backing_rom #(
        .ROM_LATENCY (ROM_LATENCY)
    ) u_rom (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_rd    (rom_rd),
        .i_addr  (rom_addr),
        .o_valid (rom_valid),
        .o_data  (rom_data)
    );

endmodule : cached_rom_top

`default_nettype wire

// File: miss_handler.sv
/*
 * Request FSM in front of the cache: lookup, check, fetch from ROM on a miss,
 * fill the cache and respond. One request at a time, no queueing.
 */
`timescale 1ns/1ps
`default_nettype none

module miss_handler import cache_pkg::*; (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_req,
    input  wire  [ADDR_W-1:0]  i_req_addr,
    output logic               o_busy,
    output logic               o_resp_valid,
    output logic [BLOCK_W-1:0] o_resp_data,
    output logic               o_resp_hit,
    output cache_cmd_t         o_cache_cmd,
    input  cache_rsp_t         i_cache_rsp,
    output logic               o_rom_rd,
    output logic [ADDR_W-1:0]  o_rom_addr,
    input  wire                i_rom_valid,
    input  wire  [BLOCK_W-1:0] i_rom_data
);
    handler_state_t state;

    logic [ADDR_W-1:0]  addr_q;    // latched request address
    logic [BLOCK_W-1:0] data_q;    // hit data from the lookup
    logic               cmd_en;
    logic               cmd_wrt;
    logic [BLOCK_W-1:0] cmd_data;

    // control path
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state        <= ST_IDLE;
            o_resp_valid <= 1'b0;
            o_rom_rd     <= 1'b0;
            cmd_en       <= 1'b0;
        end else begin
            o_resp_valid <= 1'b0;
            o_rom_rd     <= 1'b0;
            cmd_en       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        cmd_en <= 1'b1;  // lookup sampled next edge
                        state  <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: state <= ST_CHECK;
                ST_CHECK: begin
                    if (i_cache_rsp.success) begin
                        state <= ST_RESPOND;
                    end else begin
                        o_rom_rd <= 1'b1;
                        state    <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (i_rom_valid) begin
                        cmd_en <= 1'b1;  // fill write
                        state  <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    state <= ST_RESPOND;  // cache takes the write on this edge
                end
                ST_RESPOND: begin
                    o_resp_valid <= 1'b1;
                    state        <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // data path
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_req) begin
            addr_q  <= i_req_addr;
            cmd_wrt <= 1'b0;
        end
        if (state == ST_CHECK) begin
            data_q <= i_cache_rsp.data;
        end
        if (state == ST_FETCH && i_rom_valid) begin
            cmd_wrt  <= 1'b1;
            cmd_data <= i_rom_data;
        end
        if (state == ST_RESPOND) begin
            if (cmd_wrt) begin  // miss, echo of the fill is on i_cache_rsp now
                o_resp_data <= i_cache_rsp.data;
                o_resp_hit  <= 1'b0;
            end else begin
                o_resp_data <= data_q;
                o_resp_hit  <= 1'b1;
            end
        end
    end

    assign o_busy      = (state != ST_IDLE);
    assign o_rom_addr  = addr_q;
    assign o_cache_cmd = '{en: cmd_en, wrt: cmd_wrt, addr: addr_q, data: cmd_data};

    // requester has to wait while busy, strobes are dropped otherwise
    a_no_req_when_busy: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_req |-> !o_busy
    ) else $error("request strobe while busy, dropped");

    // a tag that just missed cannot be present, so the fill must be accepted
    a_fill_accepted: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (state == ST_RESPOND && cmd_wrt) |-> i_cache_rsp.success
    ) else $error("cache refused fill of address %0d", addr_q);

endmodule : miss_handler

`default_nettype wire

// File: rom_image.hex
// one 32-bit block per line, line n holds block address n
// bytes: addr, ~addr, 3c, addr ^ a5
00FF3CA5
01FE3CA4
02FD3CA7
03FC3CA6
04FB3CA1
05FA3CA0
06F93CA3
07F83CA2
08F73CAD
09F63CAC
0AF53CAF
0BF43CAE
0CF33CA9
0DF23CA8
0EF13CAB
0FF03CAA
10EF3CB5
11EE3CB4
12ED3CB7
13EC3CB6
14EB3CB1
15EA3CB0
16E93CB3
17E83CB2
18E73CBD
19E63CBC
1AE53CBF
1BE43CBE
1CE33CB9
1DE23CB8
1EE13CBB
1FE03CBA
20DF3C85
21DE3C84
22DD3C87
23DC3C86
24DB3C81
25DA3C80
26D93C83
27D83C82
28D73C8D
29D63C8C
2AD53C8F
2BD43C8E
2CD33C89
2DD23C88
2ED13C8B
2FD03C8A
30CF3C95
31CE3C94
32CD3C97
33CC3C96
34CB3C91
35CA3C90
36C93C93
37C83C92
38C73C9D
39C63C9C
3AC53C9F
3BC43C9E
3CC33C99
3DC23C98
3EC13C9B
3FC03C9A

// File: tb_cached_rom.sv
/*
 * Testbench for the cached ROM: directed and random block reads, checked
 * against a ROM image and an NMRU cache model by concurrent assertions.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cached_rom import cache_pkg::*; ();
    localparam int WAY          = 2;
    localparam int BIT_INDEX    = 2;
    localparam int ROM_LATENCY  = 3;
    localparam int SETS         = 1 << BIT_INDEX;
    localparam int HIT_LATENCY  = 3;
    localparam int MISS_LATENCY = 5 + ROM_LATENCY;
    localparam int RESP_TIMEOUT = 50;  // cycles per wait loop
    localparam int NUM_RANDOM   = 200;

    logic               i_clk;
    logic               i_rst;
    logic               i_req;
    logic [ADDR_W-1:0]  i_req_addr;
    logic               o_busy;
    logic               o_resp_valid;
    logic [BLOCK_W-1:0] o_resp_data;
    logic               o_resp_hit;

    logic [BLOCK_W-1:0] rom_words [1 << ADDR_W];
    bit                 model_valid [SETS][WAY];
    int                 model_tag   [SETS][WAY];
    int                 model_mru   [SETS];

    string              test_name = "reset";
    logic [BLOCK_W-1:0] exp_data = '0;
    logic               exp_hit = 1'b0;
    int                 exp_latency = 0;
    logic               rst_q = 1'b0;
    logic               pending = 1'b0;  // request accepted, no response yet
    int                 lat_count = 0;   // edges since the request edge
    int                 err_count = 0;
    int                 timeout_count = 0;
    int                 resp_count = 0;
    logic [31:0]        rng = 32'he136;

    cached_rom_top #(
        .WAY         (WAY),
        .BIT_INDEX   (BIT_INDEX),
        .ROM_LATENCY (ROM_LATENCY)
    ) u_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_req_addr   (i_req_addr),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_hit   (o_resp_hit)
    );

    always #50 i_clk = ~i_clk;

    // request tracking for latency and busy checks
    always @(posedge i_clk) begin
        rst_q <= i_rst;
        if (i_rst) begin
            pending   <= 1'b0;
            lat_count <= 0;
        end else if (i_req) begin
            pending   <= 1'b1;
            lat_count <= 0;
        end else begin
            if (o_resp_valid) begin
                pending <= 1'b0;
            end
            lat_count <= lat_count + 1;
        end
    end

    always @(negedge i_clk) begin
        if (o_resp_valid) begin
            resp_count++;
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk) rst_q |-> !o_resp_valid && !o_busy)
        else begin
            err_count++;
            $display("response or busy seen during reset");
        end

    a_resp_data: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid |-> o_resp_data == exp_data)
        else begin
            err_count++;
            $display("error: %s data expected %h actual %h", test_name, exp_data,
                     $sampled(o_resp_data));
        end

    a_resp_hit: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid |-> o_resp_hit == exp_hit)
        else begin
            err_count++;
            $display("error: %s hit expected %0b actual %0b", test_name, exp_hit,
                     $sampled(o_resp_hit));
        end

    a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid |-> lat_count == exp_latency)
        else begin
            err_count++;
            $display("error: %s latency expected %0d actual %0d", test_name, exp_latency,
                     $sampled(lat_count));
        end

    a_busy_held: assert property (@(posedge i_clk) disable iff (i_rst)
        pending && !o_resp_valid |-> o_busy)
        else begin
            err_count++;
            $display("o_busy dropped before the response in %s", test_name);
        end

    a_resp_requested: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid |-> pending)
        else begin
            err_count++;
            $display("response pulse without an open request in %s", test_name);
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // NMRU cache model, returns 1 on a hit
    function automatic bit model_access(input logic [ADDR_W-1:0] addr);
        int set_i;
        int tag;
        int way;
        bit found;
        set_i = addr % SETS;
        tag   = addr / SETS;
        found = 1'b0;
        way   = -1;
        for (int w = 0; w < WAY; w++) begin
            if (model_valid[set_i][w] && model_tag[set_i][w] == tag) begin
                found = 1'b1;
                way   = w;
            end
        end
        if (!found) begin
            for (int w = WAY - 1; w >= 0; w--) begin
                if (!model_valid[set_i][w]) way = w;  // lowest invalid
            end
            if (way < 0) begin
                for (int w = 0; w < WAY; w++) begin
                    if (w != model_mru[set_i]) way = w;  // highest non-MRU
                end
            end
            model_valid[set_i][way] = 1'b1;
            model_tag[set_i][way]   = tag;
        end
        model_mru[set_i] = way;
        return found;
    endfunction

    task automatic finish_run();
        $display("responses %0d, errors %0d, timeouts %0d", resp_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic read_block(input logic [ADDR_W-1:0] addr, input string name);
        int n;
        @(negedge i_clk);
        test_name   = name;
        exp_data    = rom_words[addr];
        exp_hit     = model_access(addr);
        exp_latency = exp_hit ? HIT_LATENCY : MISS_LATENCY;
        i_req       = 1'b1;
        i_req_addr  = addr;
        @(negedge i_clk);
        i_req = 1'b0;
        n = 0;
        while (!o_resp_valid && n < RESP_TIMEOUT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_resp_valid) begin
            $display("no response to the read of address %0d in %s", addr, name);
            timeout_count++;
            finish_run();
        end else begin
            n = 0;
            while (o_busy && n < RESP_TIMEOUT) begin
                @(negedge i_clk);
                n++;
            end
            if (o_busy) begin
                $display("o_busy stuck high after the response in %s", name);
                timeout_count++;
                finish_run();
            end
        end
    endtask

    initial begin
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_req      = 1'b0;
        i_req_addr = '0;
        $readmemh("rom_image.hex", rom_words);
        for (int s = 0; s < SETS; s++) begin
            model_mru[s] = 0;
            for (int w = 0; w < WAY; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = 0;
            end
        end
        repeat (2) @(negedge i_clk);
        i_rst = 1'b0;

        read_block(6'd6, "reset_first_miss");
        read_block(6'd6, "repeat_hit");

        // set 1, tags 0 1 2
        read_block(6'd1, "set_eviction");
        read_block(6'd5, "set_eviction");
        read_block(6'd9, "set_eviction");  // evicts the non-MRU block 1
        read_block(6'd5, "set_eviction");
        read_block(6'd9, "set_eviction");
        read_block(6'd1, "set_eviction");

        // set 3, a hit on 3 moves the victim to 7
        read_block(6'd3, "mru_refresh");
        read_block(6'd7, "mru_refresh");
        read_block(6'd3, "mru_refresh");
        read_block(6'd11, "mru_refresh");
        read_block(6'd3, "mru_refresh");
        read_block(6'd7, "mru_refresh");

        read_block(6'd32, "miss_latency");  // set 0 still empty

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift32(rng);
            read_block(rng[ADDR_W-1:0], "random_reads");
        end

        repeat (2) @(negedge i_clk);
        finish_run();
    end

endmodule : tb_cached_rom

`default_nettype wire
